// File: rtl/vid_settings.svh
// Video timing generator settings
// Counter and bus widths, register map and reset values
`ifndef VID_SETTINGS_SVH
`define VID_SETTINGS_SVH

// Counter and bus widths
`define VID_HW 11
`define VID_VW 11
`define VID_DW 12
`define VID_AW 5

// Mode and compare registers, read and write
`define VID_A_MODE 5'h00
`define VID_A_HP   5'h01
`define VID_A_HBB  5'h02
`define VID_A_HBE  5'h03
`define VID_A_HDB  5'h04
`define VID_A_HDE  5'h05
`define VID_A_HS   5'h06
`define VID_A_VP   5'h08
`define VID_A_VBB  5'h09
`define VID_A_VBE  5'h0a
`define VID_A_VDB  5'h0b
`define VID_A_VDE  5'h0c
`define VID_A_VS   5'h0d
`define VID_A_VI   5'h0e

// Live counters and light pen, read only
`define VID_A_HC   5'h10
`define VID_A_VC   5'h11
`define VID_A_LPH  5'h12
`define VID_A_LPV  5'h13

// Reset and idle values
`define VID_MODE_RST 2'b00
`define VID_RD_ZERO  12'h000

`endif

// File: rtl/vid_pkg.sv
// Shared types for the video timing generator
// Bus request, mode, compare sets and video outputs
`include "vid_settings.svh"

package vid_pkg;

	// Beam position
	typedef logic [`VID_HW-1:0] hpos_t;
	typedef logic [`VID_VW-1:0] vpos_t;

	// Line number with the field bit on top
	typedef struct packed {
		logic  field;
		vpos_t vpos;
	} vstat_t;

	typedef logic [`VID_DW-1:0] bus_word_t;

	// One host access, valid only, no ready
	typedef struct packed {
		logic               valid;
		logic               write;
		logic [`VID_AW-1:0] addr;
		bus_word_t          data;
	} bus_req_t;

	// Enable sits in data bit 0, interrupt enable in bit 1
	typedef struct packed {
		logic int_enable;
		logic enable;
	} vid_mode_t;

	// Horizontal compare set, all in pixels
	typedef struct packed {
		hpos_t period;
		hpos_t blank_begin;
		hpos_t blank_end;
		hpos_t disp_begin;
		hpos_t disp_end;
		hpos_t sync_begin;
	} h_timing_t;

	// Vertical compare set, all in lines
	typedef struct packed {
		vpos_t period;
		vpos_t blank_begin;
		vpos_t blank_end;
		vpos_t disp_begin;
		vpos_t disp_end;
		vpos_t sync_begin;
		vpos_t int_line;
	} v_timing_t;

	typedef struct packed {
		logic hblank;
		logic vblank;
		logic blank;
		logic hsync;
		logic vsync;
		logic start;
		logic disp_active;
	} video_out_t;

	// Next state of a set/clear window flag
	// Clear takes priority when both compares hit together
	function automatic logic window_next(input logic q, input logic set_hit, input logic clr_hit);
		logic nq;
		nq = q;
		if (clr_hit) begin
			nq = 1'b0;
		end else if (set_hit) begin
			nq = 1'b1;
		end
		return nq;
	endfunction

endpackage

// File: rtl/vid_regs.sv
`timescale 1ns/1ps
// Host register file of the video timing generator
// Write decode into mode and compare values, registered readback mux
`include "vid_settings.svh"

module vid_regs (
	input  logic               sys_clk,
	input  logic               resetl,
	input  vid_pkg::bus_req_t  req,
	input  vid_pkg::hpos_t     hpos,
	input  vid_pkg::vstat_t    vstat,
	input  vid_pkg::hpos_t     lph,
	input  vid_pkg::vstat_t    lpv_stat,
	input  logic               lp_event,
	output logic               rd_valid,
	output vid_pkg::bus_word_t rd_data,
	output vid_pkg::vid_mode_t mode,
	output vid_pkg::h_timing_t h_cfg,
	output vid_pkg::v_timing_t v_cfg
);
	import vid_pkg::*;

	logic      wr_en;
	logic      rd_en;
	hpos_t     wr_h;
	vpos_t     wr_v;
	bus_word_t rd_next;

	assign wr_en = req.valid & req.write;
	assign rd_en = req.valid & ~req.write;
	// Compare values take the low bits of the bus word
	assign wr_h = req.data[`VID_HW-1:0];
	assign wr_v = req.data[`VID_VW-1:0];

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mode <= `VID_MODE_RST;
		end else if (wr_en && req.addr == `VID_A_MODE) begin
			mode <= req.data[$bits(vid_mode_t)-1:0];
		end
	end

	// Compare registers
	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			case (req.addr)
				`VID_A_HP:  h_cfg.period      <= wr_h;
				`VID_A_HBB: h_cfg.blank_begin <= wr_h;
				`VID_A_HBE: h_cfg.blank_end   <= wr_h;
				`VID_A_HDB: h_cfg.disp_begin  <= wr_h;
				`VID_A_HDE: h_cfg.disp_end    <= wr_h;
				`VID_A_HS:  h_cfg.sync_begin  <= wr_h;
				`VID_A_VP:  v_cfg.period      <= wr_v;
				`VID_A_VBB: v_cfg.blank_begin <= wr_v;
				`VID_A_VBE: v_cfg.blank_end   <= wr_v;
				`VID_A_VDB: v_cfg.disp_begin  <= wr_v;
				`VID_A_VDE: v_cfg.disp_end    <= wr_v;
				`VID_A_VS:  v_cfg.sync_begin  <= wr_v;
				`VID_A_VI:  v_cfg.int_line    <= wr_v;
				default: ;
			endcase
		end
	end

	// Readback select, unused upper bits read as zero
	always_comb begin
		rd_next = `VID_RD_ZERO;
		case (req.addr)
			`VID_A_MODE: rd_next[$bits(vid_mode_t)-1:0] = mode;
			`VID_A_HP:   rd_next[`VID_HW-1:0] = h_cfg.period;
			`VID_A_HBB:  rd_next[`VID_HW-1:0] = h_cfg.blank_begin;
			`VID_A_HBE:  rd_next[`VID_HW-1:0] = h_cfg.blank_end;
			`VID_A_HDB:  rd_next[`VID_HW-1:0] = h_cfg.disp_begin;
			`VID_A_HDE:  rd_next[`VID_HW-1:0] = h_cfg.disp_end;
			`VID_A_HS:   rd_next[`VID_HW-1:0] = h_cfg.sync_begin;
			`VID_A_VP:   rd_next[`VID_VW-1:0] = v_cfg.period;
			`VID_A_VBB:  rd_next[`VID_VW-1:0] = v_cfg.blank_begin;
			`VID_A_VBE:  rd_next[`VID_VW-1:0] = v_cfg.blank_end;
			`VID_A_VDB:  rd_next[`VID_VW-1:0] = v_cfg.disp_begin;
			`VID_A_VDE:  rd_next[`VID_VW-1:0] = v_cfg.disp_end;
			`VID_A_VS:   rd_next[`VID_VW-1:0] = v_cfg.sync_begin;
			`VID_A_VI:   rd_next[`VID_VW-1:0] = v_cfg.int_line;
			`VID_A_HC:   rd_next[`VID_HW-1:0] = hpos;
			`VID_A_VC:   rd_next = vstat;
			`VID_A_LPH: begin
				rd_next[`VID_HW-1:0] = lph;
				// Event flag rides in the top bit
				rd_next[`VID_DW-1] = lp_event;
			end
			`VID_A_LPV:  rd_next = lpv_stat;
			default: ;
		endcase
	end

	// Response one cycle after the request
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rd_data <= rd_next;
		end
	end

endmodule

// File: rtl/vid_line_timing.sv
`timescale 1ns/1ps
// Horizontal axis of the video timing generator
// Pixel counter, blank and sync windows, display start and active window

module vid_line_timing (
	input  logic               sys_clk,
	input  logic               resetl,
	input  vid_pkg::vid_mode_t mode,
	input  vid_pkg::h_timing_t h_cfg,
	input  logic               v_disp,
	output vid_pkg::hpos_t     hpos,
	output logic               line_end,
	output logic               disp_end_hit,
	output logic               hblank,
	output logic               hsync,
	output logic               start,
	output logic               disp_active
);
	import vid_pkg::*;

	logic  run;
	logic  blank_begin_hit;
	logic  blank_end_hit;
	logic  sync_begin_hit;
	logic  start_hit;
	hpos_t hpos_next;

	// Compares only count while the generator is enabled
	assign run = mode.enable;
	assign line_end = run & (hpos == h_cfg.period);
	assign disp_end_hit = run & (hpos == h_cfg.disp_end);
	assign blank_begin_hit = run & (hpos == h_cfg.blank_begin);
	assign blank_end_hit = run & (hpos == h_cfg.blank_end);
	assign sync_begin_hit = run & (hpos == h_cfg.sync_begin);
	// Display start only inside the vertical display window
	assign start_hit = run & v_disp & (hpos == h_cfg.disp_begin);

	// Line is period+1 pixels long
	always_comb begin
		if (line_end) begin
			hpos_next = '0;
		end else begin
			hpos_next = hpos + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl || !run) begin
			hpos <= '0;
		end else begin
			hpos <= hpos_next;
		end
	end

	// Window flags follow their compares by one cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl || !run) begin
			hblank      <= 1'b0;
			hsync       <= 1'b0;
			start       <= 1'b0;
			disp_active <= 1'b0;
		end else begin
			hblank <= window_next(hblank, blank_begin_hit, blank_end_hit);
			// Sync runs to the end of the line
			hsync <= window_next(hsync, sync_begin_hit, line_end);
			start <= start_hit;
			// Active window opens together with start
			disp_active <= window_next(disp_active, start_hit, disp_end_hit);
		end
	end

endmodule

// File: rtl/vid_frame_timing.sv
`timescale 1ns/1ps
// Vertical axis of the video timing generator
// Line counter, field bit, vertical windows and line-compare interrupt

module vid_frame_timing (
	input  logic               sys_clk,
	input  logic               resetl,
	input  vid_pkg::vid_mode_t mode,
	input  vid_pkg::v_timing_t v_cfg,
	input  vid_pkg::hpos_t     hsync_begin,
	input  vid_pkg::hpos_t     hpos,
	input  logic               line_end,
	input  logic               disp_end_hit,
	output vid_pkg::vstat_t    vstat,
	output logic               field_end,
	output logic               v_disp,
	output logic               vblank,
	output logic               vsync,
	output logic               vint
);
	import vid_pkg::*;

	logic  run;
	vpos_t vpos;
	logic  field_q;
	logic  period_hit;
	logic  blank_begin_hit;
	logic  blank_end_hit;
	logic  disp_begin_hit;
	logic  disp_end_line;
	logic  sync_begin_hit;
	logic  int_hit;

	assign run = mode.enable;
	assign period_hit = vpos == v_cfg.period;
	// Last pixel of the last line
	assign field_end = line_end & period_hit;
	assign vstat = '{field: field_q, vpos: vpos};

	assign blank_begin_hit = vpos == v_cfg.blank_begin;
	assign blank_end_hit = vpos == v_cfg.blank_end;
	assign disp_begin_hit = vpos == v_cfg.disp_begin;
	assign disp_end_line = vpos == v_cfg.disp_end;
	// Vsync lines up with the horizontal sync edge
	assign sync_begin_hit = (vpos == v_cfg.sync_begin) & (hpos == hsync_begin);
	// disp_end_hit is already qualified by enable
	assign int_hit = mode.int_enable & (vpos == v_cfg.int_line) & disp_end_hit;

	// Line counter steps at each line end, field toggles on wrap
	always_ff @(posedge sys_clk) begin
		if (!resetl || !run) begin
			vpos    <= '0;
			field_q <= 1'b0;
		end else if (line_end) begin
			if (period_hit) begin
				vpos    <= '0;
				field_q <= ~field_q;
			end else begin
				vpos <= vpos + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl || !run) begin
			vblank <= 1'b0;
			v_disp <= 1'b0;
			vsync  <= 1'b0;
			vint   <= 1'b0;
		end else begin
			vblank <= window_next(vblank, blank_begin_hit, blank_end_hit);
			v_disp <= window_next(v_disp, disp_begin_hit, disp_end_line);
			vsync  <= window_next(vsync, sync_begin_hit, period_hit);
			vint   <= int_hit;
		end
	end

endmodule

// File: rtl/vid_lightpen.sv
`timescale 1ns/1ps
// Light-pen capture
// Synchronises the pen strobe, latches beam position, keeps a per-field event flag

module vid_lightpen (
	input  logic            sys_clk,
	input  logic            resetl,
	input  logic            lp,
	input  vid_pkg::hpos_t  hpos,
	input  vid_pkg::vstat_t vstat,
	input  logic            field_end,
	output vid_pkg::hpos_t  lph,
	output vid_pkg::vstat_t lpv_stat,
	output logic            lp_event
);
	logic lp_meta;
	logic lp_sync;
	logic lp_load;

	// Two-flop synchroniser on the async strobe
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lp_meta <= 1'b0;
			lp_sync <= 1'b0;
		end else begin
			lp_meta <= lp;
			lp_sync <= lp_meta;
		end
	end

	// Rising edge as seen by the second flop
	assign lp_load = lp_meta & ~lp_sync;

	always_ff @(posedge sys_clk) begin
		if (lp_load) begin
			lph      <= hpos;
			lpv_stat <= vstat;
		end
	end

	// A capture in the field-end cycle keeps the flag set
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lp_event <= 1'b0;
		end else if (lp_load) begin
			lp_event <= 1'b1;
		end else if (field_end) begin
			lp_event <= 1'b0;
		end
	end

endmodule

// File: rtl/vid_top.sv
`timescale 1ns/1ps
// Video timing generator top level
// Register file, horizontal and vertical timing and light pen

module vid_top (
	input  logic                sys_clk,
	input  logic                resetl,
	input  vid_pkg::bus_req_t   req,
	input  logic                lp,
	output logic                rd_valid,
	output vid_pkg::bus_word_t  rd_data,
	output vid_pkg::video_out_t video,
	output logic                vint
);
	import vid_pkg::*;

	vid_mode_t mode;
	h_timing_t h_cfg;
	v_timing_t v_cfg;
	hpos_t     hpos;
	vstat_t    vstat;
	hpos_t     lph;
	vstat_t    lpv_stat;
	logic      lp_event;
	logic      line_end;
	logic      disp_end_hit;
	logic      field_end;
	logic      v_disp;
	logic      hblank;
	logic      hsync;
	logic      start;
	logic      disp_active;
	logic      vblank;
	logic      vsync;

	vid_regs u_vid_regs (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.req     (req),
		.hpos    (hpos),
		.vstat   (vstat),
		.lph     (lph),
		.lpv_stat(lpv_stat),
		.lp_event(lp_event),
		.rd_valid(rd_valid),
		.rd_data (rd_data),
		.mode    (mode),
		.h_cfg   (h_cfg),
		.v_cfg   (v_cfg)
	);

	vid_line_timing u_vid_line_timing (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.mode        (mode),
		.h_cfg       (h_cfg),
		.v_disp      (v_disp),
		.hpos        (hpos),
		.line_end    (line_end),
		.disp_end_hit(disp_end_hit),
		.hblank      (hblank),
		.hsync       (hsync),
		.start       (start),
		.disp_active (disp_active)
	);

	// Vsync start shares the hsync begin compare value
	vid_frame_timing u_vid_frame_timing (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.mode        (mode),
		.v_cfg       (v_cfg),
		.hsync_begin (h_cfg.sync_begin),
		.hpos        (hpos),
		.line_end    (line_end),
		.disp_end_hit(disp_end_hit),
		.vstat       (vstat),
		.field_end   (field_end),
		.v_disp      (v_disp),
		.vblank      (vblank),
		.vsync       (vsync),
		.vint        (vint)
	);

	vid_lightpen u_vid_lightpen (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.lp       (lp),
		.hpos     (hpos),
		.vstat    (vstat),
		.field_end(field_end),
		.lph      (lph),
		.lpv_stat (lpv_stat),
		.lp_event (lp_event)
	);

	// Composite blank from both axes
	assign video = '{
		hblank:      hblank,
		vblank:      vblank,
		blank:       hblank | vblank,
		hsync:       hsync,
		vsync:       vsync,
		start:       start,
		disp_active: disp_active
	};

endmodule

// File: dv/vid_tb_checks.svh
// Typed compare tasks for the video timing testbench
// Each failing compare prints one FAIL line and bumps its own counter
`ifndef VID_TB_CHECKS_SVH
`define VID_TB_CHECKS_SVH

int n_checks = 0;
int word_errs = 0;
int hpos_errs = 0;
int vstat_errs = 0;
int bit_errs = 0;
int count_errs = 0;

task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
	n_checks++;
	if (got !== exp) begin
		word_errs++;
		$display("FAIL %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_hpos(input string name, input hpos_t got, input hpos_t exp);
	n_checks++;
	if (got !== exp) begin
		hpos_errs++;
		$display("FAIL %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_vstat(input string name, input vstat_t got, input vstat_t exp);
	n_checks++;
	if (got !== exp) begin
		vstat_errs++;
		$display("FAIL %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	n_checks++;
	if (got !== exp) begin
		bit_errs++;
		$display("FAIL %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
	end
endtask

// Cycle and pulse counts measured over a line or a frame
task automatic check_count(input string name, input int got, input int exp);
	n_checks++;
	if (got != exp) begin
		count_errs++;
		$display("FAIL %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
	end
endtask

function automatic int total_errors();
	return word_errs + hpos_errs + vstat_errs + bit_errs + count_errs;
endfunction

`endif

// File: dv/vid_tb.sv
`timescale 1ns/1ps
// Testbench for the video timing generator
// Programs timing rows over the register bus and measures whole frames
`include "vid_settings.svh"

module vid_tb;
	import vid_pkg::*;

	localparam int NROWS = 2;
	localparam int CLK_NS = 40;
	// Kinds of read waiting for their response
	localparam int RD_NONE = 0;
	localparam int RD_VC = 1;
	localparam int RD_EVT = 2;
	localparam int RD_LPH = 3;
	localparam int RD_LPV = 4;
	localparam int RD_HC = 5;
	localparam logic [`VID_AW-1:0] A_UNMAPPED = 'h07;

	// One timing program with its run length and pen offset
	typedef struct packed {
		h_timing_t h;
		v_timing_t v;
		logic      int_en;
		int        frames;
		int        lp_off;
	} row_t;

	logic       sys_clk;
	logic       resetl;
	bus_req_t   req;
	logic       lp;
	logic       rd_valid;
	bus_word_t  rd_data;
	video_out_t video;
	logic       vint;

	row_t rows [NROWS];
	logic table_ready;

	`include "vid_tb_checks.svh"

	vid_top u_vid_top (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.req     (req),
		.lp      (lp),
		.rd_valid(rd_valid),
		.rd_data (rd_data),
		.video   (video),
		.vint    (vint)
	);

	always #20 sys_clk = ~sys_clk;

	// Row 0 wraps both blank windows, row 1 runs with the interrupt off
	function automatic void fill_table();
		rows[0] = '{
			h: '{period: 11'd39, blank_begin: 11'd32, blank_end: 11'd4,
				disp_begin: 11'd6, disp_end: 11'd30, sync_begin: 11'd34},
			v: '{period: 11'd19, blank_begin: 11'd16, blank_end: 11'd2,
				disp_begin: 11'd3, disp_end: 11'd15, sync_begin: 11'd17, int_line: 11'd10},
			int_en: 1'b1, frames: 3, lp_off: 213
		};
		rows[1] = '{
			h: '{period: 11'd63, blank_begin: 11'd50, blank_end: 11'd60,
				disp_begin: 11'd8, disp_end: 11'd48, sync_begin: 11'd52},
			v: '{period: 11'd11, blank_begin: 11'd9, blank_end: 11'd11,
				disp_begin: 11'd1, disp_end: 11'd8, sync_begin: 11'd10, int_line: 11'd4},
			int_en: 1'b0, frames: 2, lp_off: 404
		};
	endfunction

	// Position inside a begin/end window that may wrap past zero
	function automatic logic in_window(input int x, input int b, input int e);
		logic hit;
		if (b <= e) begin
			hit = (x >= b) && (x < e);
		end else begin
			hit = (x >= b) || (x < e);
		end
		return hit;
	endfunction

	// Called at a falling edge, returns at the next one
	task automatic bus_write(input logic [`VID_AW-1:0] addr, input bus_word_t data);
		req = '{valid: 1'b1, write: 1'b1, addr: addr, data: data};
		@(negedge sys_clk);
		req = '0;
	endtask

	// Response is due exactly one cycle after the request
	task automatic bus_read(input logic [`VID_AW-1:0] addr, output bus_word_t data);
		req = '{valid: 1'b1, write: 1'b0, addr: addr, data: `VID_RD_ZERO};
		@(negedge sys_clk);
		req = '0;
		check_bit("rd_valid", rd_valid, 1'b1);
		data = rd_data;
	endtask

	// Stop the generator, load every compare value and read it back
	task automatic program_row(input row_t r);
		logic [`VID_AW-1:0] addrs [13];
		bus_word_t          vals [13];
		string              names [13];
		bus_word_t          rd;
		addrs = '{`VID_A_HP, `VID_A_HBB, `VID_A_HBE, `VID_A_HDB, `VID_A_HDE, `VID_A_HS,
			`VID_A_VP, `VID_A_VBB, `VID_A_VBE, `VID_A_VDB, `VID_A_VDE, `VID_A_VS, `VID_A_VI};
		names = '{"hp", "hbb", "hbe", "hdb", "hde", "hs",
			"vp", "vbb", "vbe", "vdb", "vde", "vs", "vi"};
		vals = '{bus_word_t'(r.h.period), bus_word_t'(r.h.blank_begin),
			bus_word_t'(r.h.blank_end), bus_word_t'(r.h.disp_begin),
			bus_word_t'(r.h.disp_end), bus_word_t'(r.h.sync_begin),
			bus_word_t'(r.v.period), bus_word_t'(r.v.blank_begin),
			bus_word_t'(r.v.blank_end), bus_word_t'(r.v.disp_begin),
			bus_word_t'(r.v.disp_end), bus_word_t'(r.v.sync_begin),
			bus_word_t'(r.v.int_line)};
		bus_write(`VID_A_MODE, `VID_RD_ZERO);
		bus_read(`VID_A_MODE, rd);
		check_word("mode", rd, `VID_RD_ZERO);
		for (int i = 0; i < 13; i++) begin
			bus_write(addrs[i], vals[i]);
		end
		for (int i = 0; i < 13; i++) begin
			bus_read(addrs[i], rd);
			check_word(names[i], rd, vals[i]);
		end
		bus_read(A_UNMAPPED, rd);
		check_word("unmapped", rd, `VID_RD_ZERO);
	endtask

	// One warm-up frame, then r.frames measured frames, cycle by cycle
	// Flags seen in a cycle belong to the beam position of the cycle before
	task automatic run_frames(input row_t r);
		int                 hl;
		int                 fc;
		int                 total;
		int                 meas;
		int                 pend;
		int                 last_start;
		int                 last_line;
		int                 hb_n;
		int                 hs_n;
		int                 da_n;
		int                 st_n;
		int                 vb_n;
		int                 vs_n;
		int                 vi_n;
		int                 exp_hb;
		int                 exp_hs;
		int                 exp_da;
		int                 exp_vb;
		int                 exp_vs;
		logic               exp_hbl;
		logic               exp_vbl;
		hpos_t              cur_h;
		hpos_t              prev_h;
		hpos_t              exp_lph;
		hpos_t              exp_hc;
		vpos_t              cur_v;
		vpos_t              prev_v;
		logic               cur_f;
		vstat_t             exp_vc;
		vstat_t             exp_lpv;
		logic [`VID_AW-1:0] rd_addr;
		hl = int'(r.h.period) + 1;
		fc = hl * (int'(r.v.period) + 1);
		total = fc * (r.frames + 1);
		// Window lengths from the begin and end compares, modulo the period
		exp_hb = (int'(r.h.blank_end) - int'(r.h.blank_begin) + hl) % hl;
		exp_hs = int'(r.h.period) - int'(r.h.sync_begin);
		exp_da = int'(r.h.disp_end) - int'(r.h.disp_begin);
		exp_vb = (int'(r.v.blank_end) - int'(r.v.blank_begin) + int'(r.v.period) + 1)
			% (int'(r.v.period) + 1) * hl;
		exp_vs = (int'(r.v.period) - int'(r.v.sync_begin)) * hl - int'(r.h.sync_begin);
		cur_h = '0;
		cur_v = '0;
		cur_f = 1'b0;
		prev_h = '0;
		prev_v = '0;
		exp_lph = '0;
		exp_hc = '0;
		exp_lpv = '0;
		exp_vc = '0;
		rd_addr = '0;
		pend = RD_NONE;
		last_start = 0;
		last_line = -1;
		hb_n = 0;
		hs_n = 0;
		da_n = 0;
		st_n = 0;
		vb_n = 0;
		vs_n = 0;
		vi_n = 0;
		for (int i = 0; i <= total; i++) begin
			meas = i - fc;
			check_bit("rd_valid", rd_valid, pend != RD_NONE);
			case (pend)
				RD_VC: check_vstat("vc", vstat_t'(rd_data), exp_vc);
				RD_EVT: check_bit("lp_event after a quiet field", rd_data[`VID_DW-1], 1'b0);
				RD_LPH: begin
					check_hpos("lph", rd_data[`VID_HW-1:0], exp_lph);
					check_bit("lp_event", rd_data[`VID_DW-1], 1'b1);
				end
				RD_LPV: check_vstat("lpv", vstat_t'(rd_data), exp_lpv);
				RD_HC: check_hpos("hc", rd_data[`VID_HW-1:0], exp_hc);
				default: ;
			endcase
			req = '0;
			pend = RD_NONE;
			// Measured positions only, warm-up frame skipped
			if (meas > 0) begin
				// Blank windows of the previous beam position
				exp_hbl = in_window(int'(prev_h), int'(r.h.blank_begin), int'(r.h.blank_end));
				exp_vbl = in_window(int'(prev_v), int'(r.v.blank_begin), int'(r.v.blank_end));
				check_bit("hblank", video.hblank, exp_hbl);
				check_bit("vblank", video.vblank, exp_vbl);
				check_bit("blank", video.blank, exp_hbl | exp_vbl);
				hb_n += int'(video.hblank);
				hs_n += int'(video.hsync);
				da_n += int'(video.disp_active);
				st_n += int'(video.start);
				vb_n += int'(video.vblank);
				vs_n += int'(video.vsync);
				vi_n += int'(vint);
				if (video.start) begin
					// Consecutive display lines start one line period apart
					if (int'(prev_v) == last_line + 1) begin
						check_count("start spacing", i - 1 - last_start, hl);
					end
					last_start = i - 1;
					last_line = int'(prev_v);
				end
				if (prev_h == r.h.period) begin
					check_count($sformatf("hblank cycles on line %0d", prev_v), hb_n, exp_hb);
					check_count($sformatf("hsync cycles on line %0d", prev_v), hs_n, exp_hs);
					check_count($sformatf("disp_active cycles on line %0d", prev_v), da_n,
						(prev_v >= r.v.disp_begin && prev_v < r.v.disp_end) ? exp_da : 0);
					hb_n = 0;
					hs_n = 0;
					da_n = 0;
					if (prev_v == r.v.period) begin
						check_count("start pulses per frame", st_n,
							int'(r.v.disp_end) - int'(r.v.disp_begin));
						check_count("vint pulses per frame", vi_n, int'(r.int_en));
						check_count("vblank cycles per frame", vb_n, exp_vb);
						check_count("vsync cycles per frame", vs_n, exp_vs);
						st_n = 0;
						vi_n = 0;
						vb_n = 0;
						vs_n = 0;
					end
				end
			end
			if (meas >= 0 && i < total) begin
				lp = (meas >= r.lp_off) && (meas < r.lp_off + 4);
				// Second synchroniser edge captures the position of the next cycle
				if (meas == r.lp_off + 1) begin
					exp_lph = cur_h;
					exp_lpv = '{field: cur_f, vpos: cur_v};
				end
				if (cur_v == '0 && cur_h == '0) begin
					pend = RD_VC;
					rd_addr = `VID_A_VC;
					exp_vc = '{field: cur_f, vpos: cur_v};
				end else if (cur_v == '0 && cur_h == hpos_t'(1)) begin
					pend = RD_EVT;
					rd_addr = `VID_A_LPH;
				end else if (meas == r.lp_off + 4) begin
					pend = RD_LPH;
					rd_addr = `VID_A_LPH;
				end else if (meas == r.lp_off + 5) begin
					pend = RD_LPV;
					rd_addr = `VID_A_LPV;
				end else if (meas == r.lp_off + 6) begin
					// Live pixel counter as seen in the request cycle
					pend = RD_HC;
					rd_addr = `VID_A_HC;
					exp_hc = cur_h;
				end
				if (pend != RD_NONE) begin
					req = '{valid: 1'b1, write: 1'b0, addr: rd_addr, data: `VID_RD_ZERO};
				end
			end
			prev_h = cur_h;
			prev_v = cur_v;
			// Beam model, field flips on the frame wrap
			if (cur_h == r.h.period) begin
				cur_h = '0;
				if (cur_v == r.v.period) begin
					cur_v = '0;
					cur_f = ~cur_f;
				end else begin
					cur_v = cur_v + 1'b1;
				end
			end else begin
				cur_h = cur_h + 1'b1;
			end
			@(negedge sys_clk);
		end
		lp = 1'b0;
		req = '0;
	endtask

	initial begin
		bus_word_t rd;
		sys_clk = 1'b0;
		resetl = 1'b0;
		req = '0;
		lp = 1'b0;
		table_ready = 1'b0;
		fill_table();
		table_ready = 1'b1;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;
		@(negedge sys_clk);
		check_bit("rd_valid after reset", rd_valid, 1'b0);
		check_bit("video idle after reset", |video, 1'b0);
		check_bit("vint after reset", vint, 1'b0);
		for (int r = 0; r < NROWS; r++) begin
			program_row(rows[r]);
			bus_write(`VID_A_MODE, bus_word_t'({rows[r].int_en, 1'b1}));
			run_frames(rows[r]);
			bus_read(`VID_A_MODE, rd);
			check_word("mode", rd, bus_word_t'({rows[r].int_en, 1'b1}));
		end
		$display("Checks %0d, errors: word %0d, hpos %0d, vstat %0d, bit %0d, count %0d",
			n_checks, word_errs, hpos_errs, vstat_errs, bit_errs, count_errs);
		if (total_errors() == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Limit is every frame of every row plus bus traffic and reset
	initial begin
		longint limit;
		wait (table_ready);
		limit = 64;
		for (int r = 0; r < NROWS; r++) begin
			limit += longint'(int'(rows[r].h.period) + 1) * (int'(rows[r].v.period) + 1)
				* (rows[r].frames + 1) + 64;
		end
		#(limit * CLK_NS);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+rtl
+incdir+dv
rtl/vid_pkg.sv
rtl/vid_regs.sv
rtl/vid_line_timing.sv
rtl/vid_frame_timing.sv
rtl/vid_lightpen.sv
rtl/vid_top.sv
dv/vid_tb.sv

// File: Makefile
# Verilator flow for the video timing generator

TOP := vid_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# Pass or fail comes from the pass line in the log
sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
